//--- Bender.yml
package:
  name: cpu_core

sources:
  - include_dirs:
      - .
    files:
      - cpu_pkg.sv
      - instr_decoder.sv
      - sequencer.sv
      - alu.sv
      - datapath.sv
      - cpu_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - cpu_checker.sv
      - tb_cpu.sv

//--- alu.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module alu (
	input  cpu_pkg::alu_func_e func_i,
	input  logic [`CPU_DW-1:0] a_i,
	input  logic [`CPU_DW-1:0] b_i,
	input  logic               cin_i,
	output logic [`CPU_DW-1:0] y_o,
	output logic               cout_o,
	output logic               zero_o,
	output logic               sign_o,
	output logic               ovf_o
);
	import cpu_pkg::*;

	logic [`CPU_DW-1:0] b_op;
	logic [`CPU_DW:0]   sum;

	assign b_op = (func_i == ALU_SUB) ? ~b_i : b_i;	// Borrow is inverted carry
	assign sum = {1'b0, a_i} + {1'b0, b_op} + {{`CPU_DW{1'b0}}, cin_i};

	always_comb begin
		cout_o = 1'b0;
		ovf_o = 1'b0;
		case (func_i)
			ALU_TXA: y_o = a_i;
			ALU_TXB: y_o = b_i;
			ALU_ADD, ALU_SUB: begin
				y_o = sum[`CPU_DW-1:0];
				cout_o = sum[`CPU_DW];
				// Same operand signs but a different result sign
				ovf_o = (a_i[`CPU_DW-1] == b_op[`CPU_DW-1]) &&
					(y_o[`CPU_DW-1] != a_i[`CPU_DW-1]);
			end
			ALU_AND: y_o = a_i & b_i;
			ALU_ORA: y_o = a_i | b_i;
			default: y_o = a_i ^ b_i;
		endcase
	end

	assign zero_o = (y_o == '0);
	assign sign_o = y_o[`CPU_DW-1];

endmodule

//--- cpu_checker.sv
`timescale 1ns/1ns

module cpu_checker (
	input  logic        sys,
	input  logic        rst_n_i,
	input  logic        rdy_i,
	input  logic [15:0] addr_i,
	input  logic [7:0]  data_i,
	input  logic        we_i,
	input  logic [15:0] vec_i,
	output logic        done_o,
	output int          pass_cnt_o,
	output int          fail_cnt_o
);

	int          exp_test[$];
	logic [15:0] exp_addr[$];
	logic [7:0]  exp_data[$];
	int          idx = 0;
	int          cycle_cnt = 0;
	int          cur_test;
	int          extra_writes = 0;
	int          test_err [1:6] = '{default: 0};
	bit          reported [1:6] = '{default: 0};

	initial begin
		done_o = 1'b0;
		pass_cnt_o = 0;
		fail_cnt_o = 0;
	end

	task automatic add_expect(input int t, input logic [15:0] a, input logic [7:0] d);
		exp_test.push_back(t);
		exp_addr.push_back(a);
		exp_data.push_back(d);
	endtask

	task automatic close_test(input int t);
		reported[t] = 1'b1;
		if (test_err[t] == 0) begin
			pass_cnt_o++;
			$display("Test %0d passed", t);
		end else begin
			fail_cnt_o++;
			$display("Test %0d failed with %0d errors", t, test_err[t]);
		end
	endtask

	always @(posedge sys) begin
		if (!rst_n_i) begin
			cycle_cnt = 0;
		end else if (rdy_i) begin
			// JumpL and JumpH come first, then the first fetch
			if (cycle_cnt == 2) begin
				if (addr_i !== vec_i) begin
					$display("** Error at %0t ns: addr_o expected %h, actual %h",
						$time, vec_i, addr_i);
					test_err[1]++;
				end
				close_test(1);
			end
			cycle_cnt++;
			if (we_i) begin
				if (idx >= exp_addr.size()) begin
					$display("Unexpected write of %h to address %h at %0t ns",
						data_i, addr_i, $time);
					extra_writes++;
				end else begin
					cur_test = exp_test[idx];
					if (addr_i !== exp_addr[idx]) begin
						$display("** Error at %0t ns: addr_o expected %h, actual %h",
							$time, exp_addr[idx], addr_i);
						test_err[cur_test]++;
					end
					if (data_i !== exp_data[idx]) begin
						$display("** Error at %0t ns: data_o expected %h, actual %h",
							$time, exp_data[idx], data_i);
						test_err[cur_test]++;
					end
					idx++;
					if (idx == exp_addr.size() || exp_test[idx] != cur_test)
						close_test(cur_test);	// Last write of this test
					done_o <= (idx == exp_addr.size());
				end
			end
		end
	end

	// Closes whatever is still open and judges the stalled full run
	task automatic finish_run(input logic timed_out);
		int t;
		int err_sum;
		err_sum = 0;
		for (t = 1; t <= 5; t++) begin
			if (!reported[t]) begin
				$display("Test %0d did not complete all of its bus activity", t);
				test_err[t]++;
				close_test(t);
			end
			err_sum += test_err[t];
		end
		if (idx != exp_addr.size())
			$display("Only %0d of %0d expected writes were seen", idx, exp_addr.size());
		if (timed_out || idx != exp_addr.size() || extra_writes != 0 || err_sum != 0)
			test_err[6]++;
		close_test(6);
	endtask

endmodule

//--- cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Datapath width
`define CPU_DW 8

// Low byte of the reset vector, high byte follows
`define CPU_RESET_VEC 16'hFFFC

// Bit positions in P
`define STATUS_C 0
`define STATUS_Z 1
`define STATUS_V 6
`define STATUS_N 7

`endif

//--- cpu_pkg.sv
package cpu_pkg;

	// Reduced instruction set, ILL for anything unknown
	typedef enum logic [4:0] {
		LDA, LDX, STA, STX,
		ADC, SBC, AND, ORA, EOR,
		INX, DEX, TAX, TXA,
		CLC, SEC, INC,
		BEQ, BNE, BCC, BCS,
		JMP, ILL
	} opcode_e;

	typedef enum logic [2:0] {Imp, Imm, Zp, Abs, Rel} addr_mode_e;

	typedef enum logic [3:0] {
		Fetch, Decode, Execute, WriteBack,
		JumpL, JumpH, ReadH,
		Branch, BranchOVF
	} seq_state_e;

	typedef enum logic [2:0] {
		ALU_TXA, ALU_TXB, ALU_ADD, ALU_SUB,
		ALU_AND, ALU_ORA, ALU_EOR
	} alu_func_e;

	// A side constant is zero
	typedef enum logic [2:0] {
		SRCA_CON, SRCA_ACC, SRCA_X, SRCA_DL,
		SRCA_PCL, SRCA_PCH, SRCA_ADH
	} src_a_e;

	// B side constant is one
	typedef enum logic [1:0] {SRCB_BUS, SRCB_CON, SRCB_DL} src_b_e;

	typedef enum logic [2:0] {
		DST_NONE, DST_BUS, DST_ACC, DST_X,
		DST_ADL, DST_ADH, DST_PCL, DST_PCH
	} dst_e;

endpackage

//--- cpu_top.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module cpu_top (
	input  logic               sys,
	input  logic               rst_n_i,
	input  logic               rdy_i,
	input  logic [`CPU_DW-1:0] data_i,
	output logic [15:0]        addr_o,
	output logic [`CPU_DW-1:0] data_o,
	output logic               we_o
);
	import cpu_pkg::*;

	opcode_e            opcode;
	addr_mode_e         mode;
	alu_func_e          alu_func;
	src_a_e             src_a;
	src_b_e             src_b;
	dst_e               dst;
	logic               pc_addr_oe, ad_addr_oe, pc_inc, pc_load, ins_we, alu_cinclr;
	logic [`CPU_DW-1:0] p_mask, p_set, p_clr;
	logic [`CPU_DW-1:0] ir, p, alu_a, alu_b, alu_y;
	logic               alu_cin, alu_cout, alu_zero, alu_sign, alu_ovf, dl_sign;

	instr_decoder u_dec (.ir_i(ir), .opcode_o(opcode), .mode_o(mode));

	sequencer u_seq (
		.sys(sys), .rst_n_i(rst_n_i), .rdy_i(rdy_i),
		.opcode_i(opcode), .mode_i(mode), .p_i(p),
		.dl_sign_i(dl_sign), .alu_cout_i(alu_cout),
		.we_o(we_o), .pc_addr_oe_o(pc_addr_oe), .ad_addr_oe_o(ad_addr_oe),
		.pc_inc_o(pc_inc), .pc_load_o(pc_load), .ins_we_o(ins_we),
		.alu_cinclr_o(alu_cinclr), .alu_func_o(alu_func),
		.src_a_o(src_a), .src_b_o(src_b), .dst_o(dst),
		.p_mask_o(p_mask), .p_set_o(p_set), .p_clr_o(p_clr)
	);

	alu u_alu (
		.func_i(alu_func), .a_i(alu_a), .b_i(alu_b), .cin_i(alu_cin),
		.y_o(alu_y), .cout_o(alu_cout), .zero_o(alu_zero),
		.sign_o(alu_sign), .ovf_o(alu_ovf)
	);

	datapath u_dp (
		.sys(sys), .rst_n_i(rst_n_i), .rdy_i(rdy_i),
		.pc_addr_oe_i(pc_addr_oe), .ad_addr_oe_i(ad_addr_oe),
		.pc_inc_i(pc_inc), .pc_load_i(pc_load), .ins_we_i(ins_we),
		.alu_cinclr_i(alu_cinclr), .alu_func_i(alu_func),
		.src_a_i(src_a), .src_b_i(src_b), .dst_i(dst),
		.p_mask_i(p_mask), .p_set_i(p_set), .p_clr_i(p_clr),
		.alu_y_i(alu_y), .alu_cout_i(alu_cout), .alu_zero_i(alu_zero),
		.alu_sign_i(alu_sign), .alu_ovf_i(alu_ovf), .data_i(data_i),
		.alu_a_o(alu_a), .alu_b_o(alu_b), .alu_cin_o(alu_cin),
		.ir_o(ir), .p_o(p), .dl_sign_o(dl_sign),
		.addr_o(addr_o), .data_o(data_o)
	);

endmodule

//--- datapath.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module datapath (
	input  logic               sys,
	input  logic               rst_n_i,
	input  logic               rdy_i,
	input  logic               pc_addr_oe_i,
	input  logic               ad_addr_oe_i,
	input  logic               pc_inc_i,
	input  logic               pc_load_i,
	input  logic               ins_we_i,
	input  logic               alu_cinclr_i,
	input  cpu_pkg::alu_func_e alu_func_i,
	input  cpu_pkg::src_a_e    src_a_i,
	input  cpu_pkg::src_b_e    src_b_i,
	input  cpu_pkg::dst_e      dst_i,
	input  logic [`CPU_DW-1:0] p_mask_i,
	input  logic [`CPU_DW-1:0] p_set_i,
	input  logic [`CPU_DW-1:0] p_clr_i,
	input  logic [`CPU_DW-1:0] alu_y_i,
	input  logic               alu_cout_i,
	input  logic               alu_zero_i,
	input  logic               alu_sign_i,
	input  logic               alu_ovf_i,
	input  logic [`CPU_DW-1:0] data_i,
	output logic [`CPU_DW-1:0] alu_a_o,
	output logic [`CPU_DW-1:0] alu_b_o,
	output logic               alu_cin_o,
	output logic [`CPU_DW-1:0] ir_o,
	output logic [`CPU_DW-1:0] p_o,
	output logic               dl_sign_o,
	output logic [15:0]        addr_o,
	output logic [`CPU_DW-1:0] data_o
);
	import cpu_pkg::*;

	logic [15:0]        pc;
	logic [`CPU_DW-1:0] acc, x, p, adl, adh, dl, ir;
	logic [`CPU_DW-1:0] adl_next, adh_next;
	logic [`CPU_DW-1:0] flags;

	// A jump loads the address byte written in the same cycle
	assign adl_next = (dst_i == DST_ADL) ? alu_y_i : adl;
	assign adh_next = (dst_i == DST_ADH) ? alu_y_i : adh;

	always_comb begin
		flags = '0;
		flags[`STATUS_C] = alu_cout_i;
		flags[`STATUS_Z] = alu_zero_i;
		flags[`STATUS_V] = alu_ovf_i;
		flags[`STATUS_N] = alu_sign_i;
	end

	always_ff @(posedge sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pc <= `CPU_RESET_VEC;
			p <= '0;
			ir <= '0;
		end else if (rdy_i) begin
			if (pc_load_i)
				pc <= {adh_next, adl_next};
			else if (pc_inc_i)
				pc <= pc + 16'd1;
			else if (dst_i == DST_PCL)
				pc[7:0] <= alu_y_i;
			else if (dst_i == DST_PCH)
				pc[15:8] <= alu_y_i;
			p <= ((p & ~p_mask_i) | (flags & p_mask_i) | p_set_i) & ~p_clr_i;
			if (ins_we_i)
				ir <= data_i;
		end
	end

	always_ff @(posedge sys) begin
		if (rdy_i) begin
			dl <= data_i;	// Read data of every completed cycle
			adl <= adl_next;
			adh <= adh_next;
			if (dst_i == DST_ACC)
				acc <= alu_y_i;
			if (dst_i == DST_X)
				x <= alu_y_i;
		end
	end

	always_comb begin
		case (src_a_i)
			SRCA_ACC: alu_a_o = acc;
			SRCA_X:   alu_a_o = x;
			SRCA_DL:  alu_a_o = dl;
			SRCA_PCL: alu_a_o = pc[7:0];
			SRCA_PCH: alu_a_o = pc[15:8];
			SRCA_ADH: alu_a_o = adh;
			default:  alu_a_o = '0;
		endcase
		case (src_b_i)
			SRCB_CON: alu_b_o = {{(`CPU_DW-1){1'b0}}, 1'b1};
			SRCB_DL:  alu_b_o = dl;
			default:  alu_b_o = data_i;
		endcase
	end

	assign alu_cin_o = alu_cinclr_i ? (alu_func_i == ALU_SUB) : p[`STATUS_C];
	assign addr_o = (ad_addr_oe_i && !pc_addr_oe_i) ? {adh, adl} : pc;	// PC by default
	assign data_o = (dst_i == DST_BUS) ? alu_y_i : '0;
	assign dl_sign_o = dl[`CPU_DW-1];
	assign ir_o = ir;
	assign p_o = p;

	a_pc_src: assert property (@(posedge sys) disable iff (!rst_n_i)
		!(pc_inc_i && pc_load_i));

endmodule

//--- instr_decoder.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module instr_decoder (
	input  logic [`CPU_DW-1:0]  ir_i,
	output cpu_pkg::opcode_e    opcode_o,
	output cpu_pkg::addr_mode_e mode_o
);
	import cpu_pkg::*;

	always_comb begin
		case (ir_i)
			8'hA9, 8'hA5, 8'hAD: opcode_o = LDA;
			8'hA2, 8'hA6, 8'hAE: opcode_o = LDX;
			8'h85, 8'h8D:        opcode_o = STA;
			8'h86, 8'h8E:        opcode_o = STX;
			8'h69, 8'h65, 8'h6D: opcode_o = ADC;
			8'hE9, 8'hE5, 8'hED: opcode_o = SBC;
			8'h29, 8'h25, 8'h2D: opcode_o = AND;
			8'h09, 8'h05, 8'h0D: opcode_o = ORA;
			8'h49, 8'h45, 8'h4D: opcode_o = EOR;
			8'hE8:               opcode_o = INX;
			8'hCA:               opcode_o = DEX;
			8'hAA:               opcode_o = TAX;
			8'h8A:               opcode_o = TXA;
			8'h18:               opcode_o = CLC;
			8'h38:               opcode_o = SEC;
			8'hE6, 8'hEE:        opcode_o = INC;
			8'hF0:               opcode_o = BEQ;
			8'hD0:               opcode_o = BNE;
			8'h90:               opcode_o = BCC;
			8'hB0:               opcode_o = BCS;
			8'h4C:               opcode_o = JMP;
			default:             opcode_o = ILL;
		endcase
	end

	// Only bytes of the kept set get a mode other than implied
	always_comb begin
		case (ir_i)
			8'h09, 8'h29, 8'h49, 8'h69,
			8'hA9, 8'hE9, 8'hA2:        mode_o = Imm;
			8'h05, 8'h25, 8'h45, 8'h65,
			8'h85, 8'h86, 8'hA5, 8'hA6,
			8'hE5, 8'hE6:               mode_o = Zp;
			8'h0D, 8'h2D, 8'h4C, 8'h4D,
			8'h6D, 8'h8D, 8'h8E, 8'hAD,
			8'hAE, 8'hED, 8'hEE:        mode_o = Abs;
			8'h90, 8'hB0, 8'hD0, 8'hF0: mode_o = Rel;
			default:                    mode_o = Imp;
		endcase
	end

endmodule

//--- program_input.txt
# M addr count bytes : memory image, count bytes from addr (hex)
# E test addr data : expected write in order; N count : instructions executed
N 67
M fffc 2 00 02
M 0080 6 33 44 01 06 7e ff
M 0410 4 55 66 f0 3c
M 0200 16 a9 11 85 40 a2 22 86 41 a5 80 8d 00 03 a6 81 8e
M 0210 12 01 03 ad 10 04 85 42 ae 11 04 86 43
M 021c 16 18 a9 50 69 30 85 44 38 e9 01 85 45 65 82 85 46
M 022c 16 2d 12 04 09 0f 49 ff 8d 02 03 aa e8 e8 ca 86 47
M 023c 10 a2 05 8a 85 48 18 e5 83 85 49
M 0246 16 f0 04 a9 a1 85 50 d0 04 a9 ee 85 5f a9 b2 85 51
M 0256 16 90 04 a9 ee 85 5f 38 90 04 a9 c3 85 52 b0 04 a9
M 0266 16 ee 85 5f a9 00 d0 04 85 53 f0 04 a9 ee 85 5f 4c
M 0276 2 f0 04
M 04f0 14 38 b0 20 a9 ee 85 5f a9 e5 85 55 4c 20 05
M 0513 11 a9 d4 85 54 18 90 dd a9 ee 85 5f
M 0520 13 e6 84 e6 85 ee 13 04 ee 13 04 4c 2a 05
E 2 0040 11
E 2 0041 22
E 2 0300 33
E 2 0301 44
E 2 0042 55
E 2 0043 66
E 3 0044 80
E 3 0045 7f
E 3 0046 81
E 3 0302 70
E 3 0047 71
E 3 0048 05
E 3 0049 fe
E 4 0050 a1
E 4 0051 b2
E 4 0052 c3
E 4 0053 00
E 4 0054 d4
E 4 0055 e5
E 5 0084 7f
E 5 0085 00
E 5 0413 3d
E 5 0413 3e

//--- sequencer.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module sequencer (
	input  logic                sys,
	input  logic                rst_n_i,
	input  logic                rdy_i,
	input  cpu_pkg::opcode_e    opcode_i,
	input  cpu_pkg::addr_mode_e mode_i,
	input  logic [`CPU_DW-1:0]  p_i,
	input  logic                dl_sign_i,
	input  logic                alu_cout_i,
	output logic                we_o,
	output logic                pc_addr_oe_o,
	output logic                ad_addr_oe_o,
	output logic                pc_inc_o,
	output logic                pc_load_o,
	output logic                ins_we_o,
	output logic                alu_cinclr_o,
	output cpu_pkg::alu_func_e  alu_func_o,
	output cpu_pkg::src_a_e     src_a_o,
	output cpu_pkg::src_b_e     src_b_o,
	output cpu_pkg::dst_e       dst_o,
	output logic [`CPU_DW-1:0]  p_mask_o,
	output logic [`CPU_DW-1:0]  p_set_o,
	output logic [`CPU_DW-1:0]  p_clr_o
);
	import cpu_pkg::*;

	seq_state_e state, state_next;
	logic alu_cout_prev;	// Carry out of the PCL add
	logic branch;
	logic execute;
	logic nz;

	always_ff @(posedge sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= JumpL;
			alu_cout_prev <= 1'b0;
		end else if (rdy_i) begin
			state <= state_next;
			alu_cout_prev <= alu_cout_i;
		end
	end

	always_comb begin
		case (opcode_i)
			BCC:     branch = ~p_i[`STATUS_C];
			BCS:     branch = p_i[`STATUS_C];
			BNE:     branch = ~p_i[`STATUS_Z];
			BEQ:     branch = p_i[`STATUS_Z];
			default: branch = 1'b0;
		endcase
	end

	always_comb begin
		we_o = 1'b0;
		pc_addr_oe_o = 1'b0;
		ad_addr_oe_o = 1'b0;
		pc_inc_o = 1'b0;
		pc_load_o = 1'b0;
		ins_we_o = 1'b0;
		alu_cinclr_o = 1'b0;
		alu_func_o = ALU_TXB;
		src_a_o = SRCA_CON;
		src_b_o = SRCB_BUS;
		dst_o = DST_NONE;
		p_mask_o = '0;
		p_set_o = '0;
		p_clr_o = '0;
		execute = 1'b0;
		nz = 1'b0;
		state_next = state;

		case (state)
			Fetch: begin
				pc_addr_oe_o = 1'b1;
				pc_inc_o = 1'b1;
				ins_we_o = 1'b1;
				alu_func_o = ALU_TXA;	// Zero page for ADH
				dst_o = DST_ADH;
				state_next = Decode;
			end
			Decode: begin
				pc_addr_oe_o = 1'b1;
				pc_inc_o = 1'b1;
				case (mode_i)
					Imp, Imm: begin
						pc_inc_o = (mode_i == Imm);
						execute = 1'b1;
						state_next = Fetch;
					end
					Zp, Abs: begin
						dst_o = DST_ADL;	// Operand low byte
						state_next = (mode_i == Zp) ? Execute : ReadH;
					end
					Rel: begin
						if (branch) begin
							pc_inc_o = 1'b0;
							alu_func_o = ALU_ADD;	// PCL + offset
							alu_cinclr_o = 1'b1;
							src_a_o = SRCA_PCL;
							dst_o = DST_PCL;
							state_next = Branch;
						end else begin
							state_next = Fetch;
						end
					end
					default: state_next = Fetch;
				endcase
			end
			ReadH: begin
				pc_addr_oe_o = 1'b1;
				dst_o = DST_ADH;	// Operand high byte
				if (opcode_i == JMP) begin
					pc_load_o = 1'b1;
					state_next = Fetch;
				end else begin
					pc_inc_o = 1'b1;
					state_next = Execute;
				end
			end
			Execute: begin
				ad_addr_oe_o = 1'b1;
				execute = (opcode_i != INC);
				state_next = (opcode_i == INC) ? WriteBack : Fetch;
			end
			WriteBack: begin
				ad_addr_oe_o = 1'b1;
				we_o = 1'b1;
				execute = 1'b1;
				state_next = Fetch;
			end
			Branch: begin
				pc_addr_oe_o = 1'b1;
				alu_func_o = dl_sign_i ? ALU_SUB : ALU_ADD;	// PCH fix up by one
				alu_cinclr_o = 1'b1;
				src_a_o = SRCA_PCH;
				src_b_o = SRCB_CON;
				// Page crossed when carry and offset sign disagree
				if (alu_cout_prev ^ dl_sign_i) begin
					dst_o = DST_PCH;
					state_next = BranchOVF;
				end else begin
					pc_inc_o = 1'b1;
					state_next = Fetch;
				end
			end
			BranchOVF: begin
				pc_addr_oe_o = 1'b1;
				pc_inc_o = 1'b1;
				state_next = Fetch;
			end
			JumpL: begin
				pc_addr_oe_o = 1'b1;
				pc_inc_o = 1'b1;
				dst_o = DST_ADL;	// Vector low byte
				state_next = JumpH;
			end
			JumpH: begin
				pc_addr_oe_o = 1'b1;
				pc_load_o = 1'b1;
				dst_o = DST_ADH;
				state_next = Fetch;
			end
			default: state_next = JumpL;
		endcase

		// Operation specific steering on top of the sequence
		if (execute) begin
			nz = 1'b1;
			case (opcode_i)
				LDA: dst_o = DST_ACC;	// BUS to ACC
				LDX: dst_o = DST_X;
				STA, STX: begin
					alu_func_o = ALU_TXA;
					src_a_o = (opcode_i == STA) ? SRCA_ACC : SRCA_X;
					dst_o = DST_BUS;
					we_o = 1'b1;
					nz = 1'b0;
				end
				ADC, SBC, AND, ORA, EOR: begin
					src_a_o = SRCA_ACC;	// ACC op BUS to ACC
					dst_o = DST_ACC;
					p_mask_o[`STATUS_C] = (opcode_i == ADC) || (opcode_i == SBC);
					p_mask_o[`STATUS_V] = (opcode_i == ADC) || (opcode_i == SBC);
					case (opcode_i)
						ADC:     alu_func_o = ALU_ADD;
						SBC:     alu_func_o = ALU_SUB;
						AND:     alu_func_o = ALU_AND;
						ORA:     alu_func_o = ALU_ORA;
						default: alu_func_o = ALU_EOR;
					endcase
				end
				INX, DEX: begin
					alu_func_o = (opcode_i == INX) ? ALU_ADD : ALU_SUB;
					alu_cinclr_o = 1'b1;
					src_a_o = SRCA_X;
					src_b_o = SRCB_CON;
					dst_o = DST_X;
				end
				INC: begin
					alu_func_o = ALU_ADD;	// DL + 1 onto the bus
					alu_cinclr_o = 1'b1;
					src_a_o = SRCA_DL;
					src_b_o = SRCB_CON;
					dst_o = DST_BUS;
				end
				TAX, TXA: begin
					alu_func_o = ALU_TXA;
					src_a_o = (opcode_i == TAX) ? SRCA_ACC : SRCA_X;
					dst_o = (opcode_i == TAX) ? DST_X : DST_ACC;
				end
				CLC: begin
					p_clr_o[`STATUS_C] = 1'b1;
					nz = 1'b0;
				end
				SEC: begin
					p_set_o[`STATUS_C] = 1'b1;
					nz = 1'b0;
				end
				default: nz = 1'b0;
			endcase
			p_mask_o[`STATUS_N] = nz;
			p_mask_o[`STATUS_Z] = nz;
		end
	end

	a_pc_excl: assert property (@(posedge sys) disable iff (!rst_n_i)
		!(pc_inc_o && pc_load_o));

	// Every write goes to the operand address
	a_we_addr: assert property (@(posedge sys) disable iff (!rst_n_i)
		we_o |-> ad_addr_oe_o);

	a_state_known: assert property (@(posedge sys) disable iff (!rst_n_i)
		!$isunknown(state));

endmodule

//--- tb.f
+incdir+.
cpu_pkg.sv
instr_decoder.sv
sequencer.sv
alu.sv
datapath.sv
cpu_top.sv
cpu_checker.sv
tb_cpu.sv

//--- tb_cpu.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module tb_cpu;

	logic               sys = 1'b0;
	logic               rst_n_i;
	logic               rdy_i;
	logic [`CPU_DW-1:0] data_i;
	logic [15:0]        addr_o;
	logic [`CPU_DW-1:0] data_o;
	logic               we_o;

	logic [7:0]   mem [0:65535];	// Whole 64 KiB address space
	logic [15:0]  vec;
	logic         load_ok;
	logic         timed_out;
	logic         chk_done;
	int           chk_pass_cnt;
	int           chk_fail_cnt;
	int           seed = 32'hd46f_d304;
	int           n_instr;
	int           limit;
	int           cycles;
	int           drain;

	cpu_top uut (
		.sys(sys), .rst_n_i(rst_n_i), .rdy_i(rdy_i), .data_i(data_i),
		.addr_o(addr_o), .data_o(data_o), .we_o(we_o)
	);

	cpu_checker u_chk (
		.sys(sys), .rst_n_i(rst_n_i), .rdy_i(rdy_i),
		.addr_i(addr_o), .data_i(data_o), .we_i(we_o), .vec_i(vec),
		.done_o(chk_done), .pass_cnt_o(chk_pass_cnt), .fail_cnt_o(chk_fail_cnt)
	);

	initial begin
		forever #10 sys = ~sys;	// 20 ns period
	end

	// Memory image and expected writes from the data file
	task automatic load_image(output logic ok);
		int fd;
		int code;
		int k;
		int mcnt;
		int et;
		logic [7:0]        kind;
		logic [8*200-1:0]  line;
		logic [15:0]       maddr;
		logic [7:0]        mbyte;
		logic [15:0]       ea;
		logic [7:0]        ed;
		for (k = 0; k < 65536; k++)
			mem[k] = k[15:8] ^ k[7:0] ^ 8'h5A;	// Fill from the full address
		n_instr = 0;
		fd = $fopen("program_input.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			code = $fscanf(fd, " %c", kind);
			while (code == 1) begin
				case (kind)
					"M": begin
						code = $fscanf(fd, "%h %d", maddr, mcnt);
						for (k = 0; k < mcnt; k++) begin
							code = $fscanf(fd, "%h", mbyte);
							mem[maddr + k[15:0]] = mbyte;
						end
					end
					"E": begin
						code = $fscanf(fd, "%d %h %h", et, ea, ed);
						u_chk.add_expect(et, ea, ed);
					end
					"N": code = $fscanf(fd, "%d", n_instr);
					default: code = $fgets(line, fd);	// Comment line
				endcase
				code = $fscanf(fd, " %c", kind);
			end
			$fclose(fd);
		end
		vec = {mem[`CPU_RESET_VEC + 1], mem[`CPU_RESET_VEC]};
	endtask

	// Read data and random stalls change on the falling edge
	always @(negedge sys) begin
		data_i = mem[addr_o];
		rdy_i = (($random(seed) & 3) != 0);
	end

	always @(posedge sys) begin
		if (rst_n_i && rdy_i && we_o)
			mem[addr_o] <= data_o;
	end

	initial begin
		rst_n_i = 1'b0;
		rdy_i = 1'b0;
		data_i = '0;
		vec = '0;
		timed_out = 1'b0;
		cycles = 0;
		drain = 0;
		load_image(load_ok);
		if (!load_ok) begin
			$display("Could not open program_input.txt for reading");
			$display("Test failed");
		end else begin
			limit = n_instr * 5 * 2 + 20;	// Doubled for stalls
			repeat (2) @(posedge sys);
			@(negedge sys);
			rst_n_i = 1'b1;
			// Run on a few cycles after the last write to catch strays
			while (!timed_out && drain < 12) begin
				@(posedge sys);
				cycles++;
				if (chk_done && rdy_i)
					drain++;
				if (cycles >= limit && drain < 12) begin
					timed_out = 1'b1;
					$display("Timeout: program did not finish within %0d cycles", limit);
				end
			end
			@(negedge sys);
			u_chk.finish_run(timed_out);
			$display("Tests passed: %0d, tests failed: %0d", chk_pass_cnt, chk_fail_cnt);
			if (!timed_out && chk_fail_cnt == 0 && chk_pass_cnt == 6)
				$display("Test completed successfully");
			else
				$display("Test failed");
		end
		$finish;
	end

endmodule
